/* Makefile */
# Verilator build and run of the memory back end testbench.

VERILATOR ?= verilator
TOP       ?= memBackEndTb
SEED      ?= 24588
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
FILELIST  ?= verilog.f
VFLAGS    ?= --binary --timing --assert -Wall

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the simulation, pass if $(LOG) holds TEST PASS"
	@echo "  clean  remove build output and logs"
	@echo "  help   list the targets"
	@echo "variables: VERILATOR TOP SEED LOG OBJ_DIR FILELIST VFLAGS"

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(wildcard verilog/*.sv verilog/*.svh verif/*.sv)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GseedInit=$(SEED) \
		-f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

test: $(OBJ_DIR)/V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "TEST PASS" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* verif/memBackEndTb.sv */
`timescale 1ns/1ns

`include "backEnd_consts.svh"

module memBackEndTb #(parameter int seedInit = 32'h600c);

    logic clk;
    logic rst1;
    logic en [2];
    logic flush [2];
    logic regWrite [2];
    logic memWrite [2];
    backEndPkg::resultSrcT src [2];
    backEndPkg::addrCtrlT ctrl [2];
    logic [`XLEN-1:0] alu [2];
    logic [`XLEN-1:0] wdata [2];
    logic [`REG_IDX_W-1:0] rd [2];
    logic [`XLEN-1:0] pc [2];
    logic wbRegWrite [2];
    logic [`REG_IDX_W-1:0] wbRd [2];
    logic [`XLEN-1:0] wbResult [2];

    // expected contents of both lane registers.
    logic pendV [2];
    logic [`XLEN-1:0] pendRes [2];
    logic v1 [2];
    logic v2 [2];
    logic [`REG_IDX_W-1:0] rd1 [2];
    logic [`REG_IDX_W-1:0] rd2 [2];
    logic [`XLEN-1:0] res1 [2];
    logic [`XLEN-1:0] res2 [2];
    // stores sampled but not yet committed.
    logic heldSt [2];
    logic [2:0] heldCtrl [2];
    logic [`XLEN-1:0] heldAddr [2];
    logic [`XLEN-1:0] heldData [2];
    logic [7:0] shadow [4*`MEM_WORDS];
    logic checkOn;
    integer seed;
    string testName;

    memBackEnd i_memBackEnd (
        .clk(clk), .rst1(rst1),
        .regWriteA(regWrite[0]), .resultSrcA(src[0]), .memWriteA(memWrite[0]),
        .addrCtrlA(ctrl[0]), .aluResultA(alu[0]), .writeDataA(wdata[0]), .rdA(rd[0]),
        .pcPlus8A(pc[0]), .enA(en[0]), .flushA(flush[0]),
        .regWriteB(regWrite[1]), .resultSrcB(src[1]), .memWriteB(memWrite[1]),
        .addrCtrlB(ctrl[1]), .aluResultB(alu[1]), .writeDataB(wdata[1]), .rdB(rd[1]),
        .pcPlus8B(pc[1]), .enB(en[1]), .flushB(flush[1]),
        .wbRegWriteA(wbRegWrite[0]), .wbRdA(wbRd[0]), .wbResultA(wbResult[0]),
        .wbRegWriteB(wbRegWrite[1]), .wbRdB(wbRd[1]), .wbResultB(wbResult[1])
    );

    initial begin
        clk = 0;
        forever #2 clk = ~clk;
    end

    initial begin
        #200000;
        $display("simulation ran out of time");
        $display("TEST FAIL");
        $fatal(1);
    end

    always @(posedge clk) begin
        for (int l = 0; l < 2; l++) begin
            if (rst1) begin
                v1[l] <= 0;
                v2[l] <= 0;
            end else begin
                if (en[l]) begin
                    v2[l] <= v1[l];
                    rd2[l] <= rd1[l];
                    res2[l] <= res1[l];
                end
                if (flush[l]) begin
                    v1[l] <= 0;
                    rd1[l] <= '0;
                    res1[l] <= '0;
                end else if (en[l]) begin
                    v1[l] <= pendV[l];
                    rd1[l] <= rd[l];
                    res1[l] <= pendRes[l];
                end
            end
        end
    end

    task automatic reportValue(string what, logic [`XLEN-1:0] exp, logic [`XLEN-1:0] act);
        $display("FAILED %s: %s expected %h actual %h", testName, what, exp, act);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    // outputs settle after the rising edge.
    always @(negedge clk) begin
        if (checkOn) begin
            for (int l = 0; l < 2; l++) begin
                assert (wbRegWrite[l] === v2[l])
                    else reportValue($sformatf("lane %0d regWrite", l), v2[l], wbRegWrite[l]);
                if (v2[l] && rd2[l] != 0) begin
                    assert (wbRd[l] === rd2[l])
                        else reportValue($sformatf("lane %0d rd", l), rd2[l], wbRd[l]);
                    assert (wbResult[l] === res2[l])
                        else reportValue($sformatf("lane %0d result", l), res2[l], wbResult[l]);
                end
            end
        end
    end

    function automatic logic [`XLEN-1:0] loadExp(logic [2:0] c, logic [`XLEN-1:0] addr);
        int base;
        logic [7:0] b;
        logic [15:0] h;
        base = addr[9:2] * 4;
        b = shadow[base + addr[1:0]];
        h = {shadow[base + {addr[1], 1'b1}], shadow[base + {addr[1], 1'b0}]};
        case (c)
            3'b000: return {{24{b[7]}}, b};
            3'b100: return {24'h0, b};
            3'b001: return {{16{h[15]}}, h};
            3'b101: return {16'h0, h};
            default: return {shadow[base+3], shadow[base+2], shadow[base+1], shadow[base]};
        endcase
    endfunction

    task automatic storeShadow(logic [2:0] c, logic [`XLEN-1:0] addr, logic [`XLEN-1:0] d);
        int base;
        base = addr[9:2] * 4;
        case (c[1:0])
            2'b00: shadow[base + addr[1:0]] = d[7:0];
            2'b01: begin
                shadow[base + {addr[1], 1'b0}] = d[7:0];
                shadow[base + {addr[1], 1'b1}] = d[15:8];
            end
            default: for (int i = 0; i < 4; i++) shadow[base+i] = d[i*8 +: 8];
        endcase
    endtask

    task automatic setOp(int l, logic rw, logic [1:0] s, logic mw, logic [2:0] c,
                         logic [`XLEN-1:0] a, logic [`XLEN-1:0] d, logic [4:0] r);
        regWrite[l] = rw;
        src[l] = backEndPkg::resultSrcT'(s);
        memWrite[l] = mw;
        ctrl[l] = backEndPkg::addrCtrlT'(c);
        alu[l] = a;
        wdata[l] = d;
        rd[l] = r;
        pc[l] = $random(seed);
    endtask

    task automatic setNop(int l);
        setOp(l, 0, 2'b00, 0, 3'b010, '0, '0, '0);
    endtask

    // stores commit at the next edge where their lane advances.
    task automatic issuePair();
        for (int l = 0; l < 2; l++) begin
            if (en[l] && heldSt[l]) storeShadow(heldCtrl[l], heldAddr[l], heldData[l]);
        end
        for (int l = 0; l < 2; l++) begin
            pendV[l] = regWrite[l];
            case (src[l])
                backEndPkg::memRes: pendRes[l] = loadExp(ctrl[l], alu[l]);
                backEndPkg::pcLink: pendRes[l] = pc[l];
                default: pendRes[l] = alu[l];
            endcase
        end
        for (int l = 0; l < 2; l++) begin
            if (flush[l]) begin
                heldSt[l] = 0;
            end else if (en[l]) begin
                heldSt[l] = memWrite[l];
                heldCtrl[l] = ctrl[l];
                heldAddr[l] = alu[l];
                heldData[l] = wdata[l];
            end
        end
        @(negedge clk);
    endtask

    task automatic drain();
        int n;
        setNop(0);
        setNop(1);
        n = 0;
        while (v1[0] || v1[1] || v2[0] || v2[1]) begin
            if (n == 20) begin
                $display("pipeline did not drain in %s", testName);
                $display("TEST FAIL");
                $fatal(1);
            end
            issuePair();
            n++;
        end
    endtask

    initial begin
        seed = seedInit;
        checkOn = 0;
        rst1 = 1;
        for (int l = 0; l < 2; l++) begin
            en[l] = 1;
            flush[l] = 0;
            // live write-backs at the inputs while in reset.
            setOp(l, 1, 2'b10, 0, 3'b010, '0, '0, 5'(l + 1));
            pendV[l] = 0;
            pendRes[l] = '0;
            heldSt[l] = 0;
        end
        testName = "reset";
        @(posedge clk);
        checkOn = 1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst1 = 0;
        setNop(0);
        setNop(1);
        repeat (3) issuePair();

        testName = "passThrough";
        for (int i = 0; i < 8; i++) begin
            for (int l = 0; l < 2; l++) begin
                setOp(l, 1, ((i + l) % 3 == 1) ? 2'b10 : ((i + l) % 3 == 2) ? 2'b11 : 2'b00,
                      0, 3'b010, $random(seed), '0, 5'(1 + i + 8 * l));
            end
            issuePair();
        end
        drain();

        testName = "wordStoreLoad";
        for (int i = 0; i < 6; i++) begin
            setOp(0, 0, 2'b00, 1, 3'b010, 32'h40 + 4 * i, $random(seed), '0);
            setNop(1);
            issuePair();
        end
        for (int i = 0; i < 6; i++) begin
            setNop(1 - i % 2);
            setOp(i % 2, 1, 2'b01, 0, 3'b010, 32'h40 + 4 * i, '0, 5'(i + 1));
            issuePair();
        end
        drain();

        testName = "subWord";
        setOp(0, 0, 2'b00, 1, 3'b010, 32'h200, $random(seed), '0);
        setOp(1, 0, 2'b00, 1, 3'b010, 32'h204, $random(seed), '0);
        issuePair();
        for (int k = 0; k < 4; k++) begin
            setOp(0, 0, 2'b00, 1, 3'b000, 32'h200 + k, $random(seed), '0);
            setOp(1, 0, 2'b00, 1, 3'b001, 32'h204 + k, $random(seed), '0);
            issuePair();
            for (int c = 0; c < 5; c++) begin
                for (int j = 0; j < 4; j++) begin
                    setOp(0, 1, 2'b01, 0, 3'(c == 2 ? 3'b010 : c < 2 ? c : c + 1),
                          32'h200 + j, '0, 5'(j + 1));
                    setOp(1, 1, 2'b01, 0, ctrl[0], 32'h204 + j, '0, 5'(j + 5));
                    issuePair();
                end
            end
        end
        drain();

        testName = "sameWordStores";
        setOp(0, 0, 2'b00, 1, 3'b010, 32'h300, $random(seed), '0);
        setOp(1, 0, 2'b00, 1, 3'b001, 32'h302, $random(seed), '0);
        issuePair();
        setOp(0, 0, 2'b00, 1, 3'b001, 32'h300, $random(seed), '0);
        setOp(1, 0, 2'b00, 1, 3'b000, 32'h301, $random(seed), '0);
        issuePair();
        setOp(0, 1, 2'b01, 0, 3'b010, 32'h300, '0, 5'd3);
        setOp(1, 1, 2'b01, 0, 3'b010, 32'h300, '0, 5'd4);
        issuePair();
        drain();

        testName = "stall";
        setOp(0, 0, 2'b00, 1, 3'b010, 32'h380, $random(seed), '0);
        setNop(1);
        issuePair();
        en[0] = 0;
        for (int i = 0; i < 3; i++) begin
            setOp(0, 1, 2'b00, 1, 3'b010, 32'h380, $random(seed), 5'd9);
            setOp(1, 1, 2'b00, 0, 3'b010, $random(seed), '0, 5'(i + 1));
            issuePair();
        end
        en[0] = 1;
        drain();
        setOp(1, 1, 2'b01, 0, 3'b010, 32'h380, '0, 5'd7);
        issuePair();
        drain();

        // lane a reads the word while the lane b store is held.
        setOp(0, 0, 2'b00, 1, 3'b010, 32'h384, $random(seed), '0);
        setOp(1, 0, 2'b00, 1, 3'b010, 32'h384, $random(seed), '0);
        issuePair();
        en[1] = 0;
        for (int i = 0; i < 3; i++) begin
            setOp(0, 1, 2'b01, 0, 3'b010, 32'h384, '0, 5'(i + 1));
            setOp(1, 1, 2'b00, 1, 3'b010, 32'h384, $random(seed), 5'd9);
            issuePair();
        end
        en[1] = 1;
        drain();
        setOp(0, 1, 2'b01, 0, 3'b010, 32'h384, '0, 5'd7);
        issuePair();
        drain();

        testName = "flush";
        flush[0] = 1;
        flush[1] = 1;
        setOp(0, 1, 2'b00, 1, 3'b010, 32'h380, $random(seed), 5'd5);
        setOp(1, 1, 2'b10, 0, 3'b010, '0, '0, 5'd6);
        issuePair();
        flush[0] = 0;
        flush[1] = 0;
        drain();
        setOp(0, 1, 2'b01, 0, 3'b010, 32'h380, '0, 5'd8);
        issuePair();
        drain();

        $display("TEST PASS");
        $finish;
    end

endmodule

/* verif/memBackEnd_asserts.sv */
`timescale 1ns/1ns

module memBackEnd_asserts (
    input logic        clk,
    input logic        rst1,
    input logic        enA,
    input logic        enB,
    input logic        flushA,
    input logic        flushB,
    input logic        wbRegWriteA,
    input logic        wbRegWriteB,
    input logic [4:0]  wbRdA,
    input logic [4:0]  wbRdB,
    input logic [31:0] wbResultA,
    input logic [31:0] wbResultB
);

    // write-back is quiet right after a reset edge.
    resetQuiet: assert property (@(posedge clk) rst1 |=> !wbRegWriteA && !wbRegWriteB)
        else $error("write-back asserted after reset");

    // a flushed instruction leaves a bubble once the lane advances.
    flushBubbleA: assert property (@(posedge clk) disable iff (rst1)
        flushA ##1 enA |=> !wbRegWriteA)
        else $error("flushed instruction wrote back in lane A");
    flushBubbleB: assert property (@(posedge clk) disable iff (rst1)
        flushB ##1 enB |=> !wbRegWriteB)
        else $error("flushed instruction wrote back in lane B");

    stallHoldA: assert property (@(posedge clk) disable iff (rst1)
        !enA |=> $stable(wbRdA) && $stable(wbResultA) && $stable(wbRegWriteA))
        else $error("lane A outputs moved while stalled");
    stallHoldB: assert property (@(posedge clk) disable iff (rst1)
        !enB |=> $stable(wbRdB) && $stable(wbResultB) && $stable(wbRegWriteB))
        else $error("lane B outputs moved while stalled");

endmodule

bind memBackEnd memBackEnd_asserts asserts (
    .clk        (clk),
    .rst1       (rst1),
    .enA        (enA),
    .enB        (enB),
    .flushA     (flushA),
    .flushB     (flushB),
    .wbRegWriteA(wbRegWriteA),
    .wbRegWriteB(wbRegWriteB),
    .wbRdA      (wbRdA),
    .wbRdB      (wbRdB),
    .wbResultA  (wbResultA),
    .wbResultB  (wbResultB)
);

/* verilog.f */
+incdir+verilog
verilog/backEndPkg.sv
verilog/pipeReg.sv
verilog/loadStoreAlign.sv
verilog/dataMemory.sv
verilog/memoryStage.sv
verilog/memBackEnd.sv
verif/memBackEnd_asserts.sv
verif/memBackEndTb.sv

/* verilog/backEndPkg.sv */
`include "backEnd_consts.svh"

package backEndPkg;

    // rv32 funct3 of loads and stores.
    typedef enum logic [2:0] {
        byteS = 3'b000,
        halfS = 3'b001,
        word  = 3'b010,
        byteU = 3'b100,
        halfU = 3'b101
    } addrCtrlT;

    // write-back source, 11 falls back to the alu.
    typedef enum logic [1:0] {
        aluRes = 2'b00,
        memRes = 2'b01,
        pcLink = 2'b10
    } resultSrcT;

    typedef struct packed {
        logic                  regWrite;
        resultSrcT             resultSrc;
        logic                  memWrite;
        addrCtrlT              addrCtrl;
        logic [`XLEN-1:0]      aluResult;
        logic [`XLEN-1:0]      writeData;
        logic [`REG_IDX_W-1:0] rd;
        logic [`XLEN-1:0]      pcPlus8;
    } exMemT;

    typedef struct packed {
        logic                  regWrite;
        logic [`REG_IDX_W-1:0] rd;
        logic [`XLEN-1:0]      result;
    } memWbT;

endpackage

/* verilog/backEnd_consts.svh */
`ifndef BACKEND_CONSTS_SVH
`define BACKEND_CONSTS_SVH

// data and address width.
`define XLEN 32

// destination register index width.
`define REG_IDX_W 5

// data memory depth in words.
`define MEM_WORDS 256

// word index width, taken from alu result bits above the byte offset.
`define MEM_IDX_W $clog2(`MEM_WORDS)

`endif

/* verilog/dataMemory.sv */
`timescale 1ns/1ns

`include "backEnd_consts.svh"

module dataMemory (
    input  logic                  clk,
    input  logic [`MEM_IDX_W-1:0] addrA,
    input  logic [`MEM_IDX_W-1:0] addrB,
    input  logic [3:0]            byteEnA,
    input  logic [3:0]            byteEnB,
    input  logic [`XLEN-1:0]      wrDataA,
    input  logic [`XLEN-1:0]      wrDataB,
    input  logic                  commitA,
    input  logic                  commitB,
    output logic [`XLEN-1:0]      rdDataA,
    output logic [`XLEN-1:0]      rdDataB
);

    logic [`XLEN-1:0] mem [`MEM_WORDS];

    always_ff @(posedge clk) begin
        // lane a first.
        if (commitA) begin
            for (int i = 0; i < 4; i++) begin
                if (byteEnA[i]) begin
                    mem[addrA][i*8 +: 8] <= wrDataA[i*8 +: 8];
                end
            end
        end

        // lane b second so it wins shared bytes.
        if (commitB) begin
            for (int i = 0; i < 4; i++) begin
                if (byteEnB[i]) begin
                    mem[addrB][i*8 +: 8] <= wrDataB[i*8 +: 8];
                end
            end
        end
    end

    // reads see contents before this edge.
    assign rdDataA = mem[addrA];
    assign rdDataB = mem[addrB];

endmodule

/* verilog/loadStoreAlign.sv */
`timescale 1ns/1ns

`include "backEnd_consts.svh"

module loadStoreAlign (
    input  backEndPkg::addrCtrlT addrCtrl,
    input  logic [1:0]           addrLow,
    input  logic [`XLEN-1:0]     storeData,
    input  logic                 memWrite,
    output logic [3:0]           byteEn,
    output logic [`XLEN-1:0]     storeWord,
    input  logic [`XLEN-1:0]     readWord,
    output logic [`XLEN-1:0]     loadData
);

    logic [2:0]       ctrlBits;
    logic [1:0]       size;
    logic             unsignedLoad;
    logic [1:0]       offset;
    logic [3:0]       sizeMask;
    logic [`XLEN-1:0] shiftedRead;
    logic [7:0]       loadByte;
    logic [15:0]      loadHalf;

    assign ctrlBits     = addrCtrl;
    assign size         = ctrlBits[1:0];
    assign unsignedLoad = ctrlBits[2];

    // offset aligned down to the access size.
    always_comb begin
        case (size)
            2'b00: begin
                offset   = addrLow;
                sizeMask = 4'b0001;
            end
            2'b01: begin
                offset   = {addrLow[1], 1'b0};
                sizeMask = 4'b0011;
            end
            default: begin
                offset   = 2'b00;
                sizeMask = 4'b1111;
            end
        endcase
    end

    assign byteEn    = memWrite ? (sizeMask << offset) : 4'b0000;
    assign storeWord = storeData << {offset, 3'b000}; // lanes outside byteEn are ignored.

    assign shiftedRead = readWord >> {offset, 3'b000};
    assign loadByte    = shiftedRead[7:0];
    assign loadHalf    = shiftedRead[15:0];

    always_comb begin
        case (size)
            2'b00: begin
                if (unsignedLoad) begin
                    loadData = {{(`XLEN-8){1'b0}}, loadByte};
                end else begin
                    loadData = {{(`XLEN-8){loadByte[7]}}, loadByte};
                end
            end
            2'b01: begin
                if (unsignedLoad) begin
                    loadData = {{(`XLEN-16){1'b0}}, loadHalf};
                end else begin
                    loadData = {{(`XLEN-16){loadHalf[15]}}, loadHalf};
                end
            end
            default: begin
                loadData = readWord; // full word, no extension.
            end
        endcase
    end

endmodule

/* verilog/memBackEnd.sv */
`timescale 1ns/1ns

`include "backEnd_consts.svh"

module memBackEnd (
    input  logic                  clk,
    input  logic                  rst1,

    input  logic                  regWriteA,
    input  backEndPkg::resultSrcT resultSrcA,
    input  logic                  memWriteA,
    input  backEndPkg::addrCtrlT  addrCtrlA,
    input  logic [`XLEN-1:0]      aluResultA,
    input  logic [`XLEN-1:0]      writeDataA,
    input  logic [`REG_IDX_W-1:0] rdA,
    input  logic [`XLEN-1:0]      pcPlus8A,
    input  logic                  enA,
    input  logic                  flushA,

    input  logic                  regWriteB,
    input  backEndPkg::resultSrcT resultSrcB,
    input  logic                  memWriteB,
    input  backEndPkg::addrCtrlT  addrCtrlB,
    input  logic [`XLEN-1:0]      aluResultB,
    input  logic [`XLEN-1:0]      writeDataB,
    input  logic [`REG_IDX_W-1:0] rdB,
    input  logic [`XLEN-1:0]      pcPlus8B,
    input  logic                  enB,
    input  logic                  flushB,

    output logic                  wbRegWriteA,
    output logic [`REG_IDX_W-1:0] wbRdA,
    output logic [`XLEN-1:0]      wbResultA,
    output logic                  wbRegWriteB,
    output logic [`REG_IDX_W-1:0] wbRdB,
    output logic [`XLEN-1:0]      wbResultB
);

    backEndPkg::exMemT exInA;
    backEndPkg::exMemT exInB;
    backEndPkg::exMemT exOutA;
    backEndPkg::exMemT exOutB;
    backEndPkg::memWbT wbInA;
    backEndPkg::memWbT wbInB;
    backEndPkg::memWbT wbOutA;
    backEndPkg::memWbT wbOutB;

    always_comb begin
        exInA.regWrite  = regWriteA;
        exInA.resultSrc = resultSrcA;
        exInA.memWrite  = memWriteA;
        exInA.addrCtrl  = addrCtrlA;
        exInA.aluResult = aluResultA;
        exInA.writeData = writeDataA;
        exInA.rd        = rdA;
        exInA.pcPlus8   = pcPlus8A;

        exInB.regWrite  = regWriteB;
        exInB.resultSrc = resultSrcB;
        exInB.memWrite  = memWriteB;
        exInB.addrCtrl  = addrCtrlB;
        exInB.aluResult = aluResultB;
        exInB.writeData = writeDataB;
        exInB.rd        = rdB;
        exInB.pcPlus8   = pcPlus8B;
    end

    pipeReg exMemA (.clk(clk), .rst1(rst1), .en(enA), .flush(flushA), .d(exInA), .q(exOutA));
    pipeReg exMemB (.clk(clk), .rst1(rst1), .en(enB), .flush(flushB), .d(exInB), .q(exOutB));

    memoryStage memStage (
        .clk(clk),
        .exA(exOutA),
        .exB(exOutB),
        .enA(enA),
        .enB(enB),
        .wbA(wbInA),
        .wbB(wbInB)
    );

    // flush only kills the incoming instruction, never the one in flight.
    pipeReg #(.payloadT(backEndPkg::memWbT)) memWbA (
        .clk(clk), .rst1(rst1), .en(enA), .flush(1'b0), .d(wbInA), .q(wbOutA)
    );
    pipeReg #(.payloadT(backEndPkg::memWbT)) memWbB (
        .clk(clk), .rst1(rst1), .en(enB), .flush(1'b0), .d(wbInB), .q(wbOutB)
    );

    assign wbRegWriteA = wbOutA.regWrite;
    assign wbRdA       = wbOutA.rd;
    assign wbResultA   = wbOutA.result;
    assign wbRegWriteB = wbOutB.regWrite;
    assign wbRdB       = wbOutB.rd;
    assign wbResultB   = wbOutB.result;

endmodule

/* verilog/memoryStage.sv */
`timescale 1ns/1ns

`include "backEnd_consts.svh"

module memoryStage (
    input  logic              clk,
    input  backEndPkg::exMemT exA,
    input  backEndPkg::exMemT exB,
    input  logic              enA,
    input  logic              enB,
    output backEndPkg::memWbT wbA,
    output backEndPkg::memWbT wbB
);

    logic [3:0]       byteEnA;
    logic [3:0]       byteEnB;
    logic [`XLEN-1:0] storeWordA;
    logic [`XLEN-1:0] storeWordB;
    logic [`XLEN-1:0] readWordA;
    logic [`XLEN-1:0] readWordB;
    logic [`XLEN-1:0] loadDataA;
    logic [`XLEN-1:0] loadDataB;

    function automatic logic [`XLEN-1:0] selectResult(
        input backEndPkg::exMemT ex,
        input logic [`XLEN-1:0]  load
    );
        case (ex.resultSrc)
            backEndPkg::memRes: return load;
            backEndPkg::pcLink: return ex.pcPlus8;
            default:            return ex.aluResult;
        endcase
    endfunction

    loadStoreAlign alignA (
        .addrCtrl (exA.addrCtrl),
        .addrLow  (exA.aluResult[1:0]),
        .storeData(exA.writeData),
        .memWrite (exA.memWrite),
        .byteEn   (byteEnA),
        .storeWord(storeWordA),
        .readWord (readWordA),
        .loadData (loadDataA)
    );

    loadStoreAlign alignB (
        .addrCtrl (exB.addrCtrl),
        .addrLow  (exB.aluResult[1:0]),
        .storeData(exB.writeData),
        .memWrite (exB.memWrite),
        .byteEn   (byteEnB),
        .storeWord(storeWordB),
        .readWord (readWordB),
        .loadData (loadDataB)
    );

    // a store commits on the edge its lane advances.
    dataMemory dmem (
        .clk    (clk),
        .addrA  (exA.aluResult[`MEM_IDX_W+1:2]),
        .addrB  (exB.aluResult[`MEM_IDX_W+1:2]),
        .byteEnA(byteEnA),
        .byteEnB(byteEnB),
        .wrDataA(storeWordA),
        .wrDataB(storeWordB),
        .commitA(enA),
        .commitB(enB),
        .rdDataA(readWordA),
        .rdDataB(readWordB)
    );

    always_comb begin
        wbA.regWrite = exA.regWrite;
        wbA.rd       = exA.rd;
        wbA.result   = selectResult(exA, loadDataA);
        wbB.regWrite = exB.regWrite;
        wbB.rd       = exB.rd;
        wbB.result   = selectResult(exB, loadDataB);
    end

endmodule

/* verilog/pipeReg.sv */
`timescale 1ns/1ns

module pipeReg #(
    parameter type payloadT = backEndPkg::exMemT
) (
    input  logic    clk,
    input  logic    rst1,
    input  logic    en,
    input  logic    flush,
    input  payloadT d,
    output payloadT q
);

    always_ff @(posedge clk) begin
        if (rst1) begin
            q <= '0;
        end else if (flush) begin
            // bubble, even while stalled.
            q <= '0;
        end else if (en) begin
            q <= d;
        end
    end

endmodule
